/* hw/conv_out_fifo_bank.sv */
`timescale 1ns/10ps
`include "conv_store_cfg.svh"

module conv_out_fifo_bank (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wr_en,
  input  conv_store_pkg::fifo_wr_t      wr,
  input  logic                          rd_en,
  input  logic [3:0]                    rd_index,
  output logic [`CS_FIFO_WIDTH-1:0]     rd_data
);

  localparam int PTR_W = $clog2(`CS_FIFO_DEPTH);

  logic [`CS_FIFO_WIDTH-1:0] mem [`CS_FIFO_NUM][`CS_FIFO_DEPTH];
  logic [PTR_W-1:0]          wr_ptr [`CS_FIFO_NUM];
  logic [PTR_W-1:0]          rd_ptr [`CS_FIFO_NUM];
  logic                      wr_hit;
  logic                      rd_hit;
  logic [PTR_W-1:0]          wr_slot;
  logic [PTR_W-1:0]          rd_slot;

  // indexes past the last fifo are dropped
  assign wr_hit = wr_en && (wr.index < 4'(`CS_FIFO_NUM));
  assign rd_hit = rd_en && (rd_index < 4'(`CS_FIFO_NUM));

  assign wr_slot = wr_hit ? wr_ptr[wr.index] : '0;
  assign rd_slot = rd_hit ? rd_ptr[rd_index] : '0;

  ////////////////////////////////
  // pointers
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CS_FIFO_NUM; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
      end
    end else begin
      // circular, wraps at depth
      if (wr_hit) begin
        wr_ptr[wr.index] <= wr_slot + 1'b1;
      end
      if (rd_hit) begin
        rd_ptr[rd_index] <= rd_slot + 1'b1;
      end
    end
  end

  ////////////////////////////////
  // storage
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr.index][wr_slot] <= wr.data;
    end
  end

  // registered read, data one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      rd_data <= mem[rd_index][rd_slot];
    end
  end

endmodule

/* hw/conv_store_cfg.svh */
`ifndef CONV_STORE_CFG_SVH
`define CONV_STORE_CFG_SVH

////////////////////////////////
// systolic array geometry
////////////////////////////////

`define CS_SA_ROWS 4
`define CS_SA_COLS 3

// one row fifo per array row and column slot
`define CS_FIFO_NUM (`CS_SA_ROWS * `CS_SA_COLS)
`define CS_FIFO_DEPTH 32
`define CS_FIFO_WIDTH 512

////////////////////////////////
// conv word packing
////////////////////////////////

// 8x8 mode word, half a ddr beat
`define CS_CONV_WORD 256

// channels per array row in 8x8 mode, 1x8 doubles it
`define CS_ROWS_IN_SA 16
`define CS_ROWS_IN_SA_LOG2 4

// pixels per ddr row word group
`define CS_PIXELS_LOG2 5

// longest ddr write command in words
`define CS_CMD_WORDS 32

`endif

/* hw/conv_store_fsm.sv */
`timescale 1ns/10ps

module conv_store_fsm (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          store_start,
  input  conv_store_pkg::tile_desc_t    tile,
  input  logic                          ddr_cmd_ready,
  input  logic                          cmd_last,
  input  logic                          burst_done,
  input  logic                          tile_done,
  output conv_store_pkg::store_state_e  state,
  output logic                          cmd_issue,
  output logic                          store_fin
);

  conv_store_pkg::tile_desc_t tile_q;
  logic                       last_cmd_q;
  logic                       tile_empty;

  // nothing to store for a zero sized tile
  assign tile_empty = (tile_q.poy == 16'd0) || (tile_q.pof == 16'd0);

  assign cmd_issue = (state == conv_store_pkg::ST_CMD) && ddr_cmd_ready && !tile_empty;
  assign store_fin = (state == conv_store_pkg::ST_DONE);

  always_ff @(posedge clk) begin
    if ((state == conv_store_pkg::ST_IDLE) && store_start) begin
      tile_q <= tile;
    end
  end

  ////////////////////////////////
  // state register
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= conv_store_pkg::ST_IDLE;
      last_cmd_q <= 1'b0;
    end else begin
      case (state)
        conv_store_pkg::ST_IDLE: begin
          last_cmd_q <= 1'b0;
          if (store_start) begin
            state <= conv_store_pkg::ST_CMD;
          end
        end
        conv_store_pkg::ST_CMD: begin
          if (tile_empty) begin
            state <= conv_store_pkg::ST_DONE;
          end else if (cmd_issue) begin
            last_cmd_q <= cmd_last;
            state      <= conv_store_pkg::ST_DATA;
          end
        end
        conv_store_pkg::ST_DATA: begin
          // leave on the last beat of the burst
          if (burst_done) begin
            if (last_cmd_q && tile_done) begin
              state <= conv_store_pkg::ST_DONE;
            end else begin
              state <= conv_store_pkg::ST_CMD;
            end
          end
        end
        default: begin
          state <= conv_store_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* hw/conv_store_pkg.sv */
`include "conv_store_cfg.svh"

package conv_store_pkg;

  typedef enum logic {
    MODE_8X8 = 1'b0,
    MODE_1X8 = 1'b1
  } store_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CMD  = 2'd1,
    ST_DATA = 2'd2,
    ST_DONE = 2'd3
  } store_state_e;

  // start fields count from 1
  typedef struct packed {
    logic [31:0] layer_base;
    store_mode_e mode;
    logic [3:0]  of_log2;
    logic [3:0]  ox_log2;
    logic [15:0] ox_start;
    logic [15:0] oy_start;
    logic [15:0] of_start;
    logic [15:0] poy;
    logic [15:0] pof;
  } tile_desc_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [15:0] length;
  } ddr_cmd_t;

  typedef struct packed {
    logic [31:0]                addr;
    logic [`CS_FIFO_WIDTH-1:0] data;
  } ddr_beat_t;

  typedef struct packed {
    logic [3:0]                 index;
    logic [`CS_FIFO_WIDTH-1:0] data;
  } fifo_wr_t;

  // oy from 1, of_base and channel from 0
  typedef struct packed {
    logic [15:0] oy;
    logic [15:0] of_base;
    logic [15:0] channel;
  } loop_pos_t;

  // words in the next command, two channels per word
  function automatic logic [15:0] cmd_length(input logic [15:0] pof, input logic [15:0] ch_off);
    logic [15:0] left;
    left = pof - ch_off;
    if (left >= 16'(2 * `CS_CMD_WORDS)) begin
      return 16'(`CS_CMD_WORDS);
    end
    return left >> 1;
  endfunction

endpackage

/* hw/conv_store_top.sv */
`timescale 1ns/10ps
`include "conv_store_cfg.svh"

module conv_store_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        fifo_wr_en,
  input  conv_store_pkg::fifo_wr_t    fifo_wr,
  input  conv_store_pkg::tile_desc_t  tile,
  input  logic                        store_start,
  input  logic                        ddr_cmd_ready,
  input  logic                        ddr_data_ready,
  output logic                        cmd_valid,
  output conv_store_pkg::ddr_cmd_t    cmd,
  output logic                        beat_valid,
  output conv_store_pkg::ddr_beat_t   beat,
  output logic                        store_fin
);

  conv_store_pkg::store_state_e state;
  conv_store_pkg::loop_pos_t    pos;
  logic                         cmd_issue;
  logic                         cmd_last;
  logic                         burst_done;
  logic                         tile_done;
  logic                         rd_en;
  logic [3:0]                   rd_index;
  logic                         pair_second;
  logic [15:0]                  cmd_of;
  logic [15:0]                  cmd_row;
  logic [`CS_FIFO_WIDTH-1:0]    rd_data;
  logic [31:0]                  beat_addr;
  logic                         rd_valid;

  assign cmd_valid = cmd_issue;

  // matches the fifo read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  conv_store_fsm u_fsm (
    .clk           (clk),
    .reset         (reset),
    .store_start   (store_start),
    .tile          (tile),
    .ddr_cmd_ready (ddr_cmd_ready),
    .cmd_last      (cmd_last),
    .burst_done    (burst_done),
    .tile_done     (tile_done),
    .state         (state),
    .cmd_issue     (cmd_issue),
    .store_fin     (store_fin)
  );

  store_loop_counter u_loop (
    .clk            (clk),
    .reset          (reset),
    .state          (state),
    .tile           (tile),
    .cmd_issue      (cmd_issue),
    .ddr_data_ready (ddr_data_ready),
    .rd_en          (rd_en),
    .rd_index       (rd_index),
    .pos            (pos),
    .pair_second    (pair_second),
    .cmd_of         (cmd_of),
    .cmd_row        (cmd_row),
    .cmd_last       (cmd_last),
    .burst_done     (burst_done),
    .tile_done      (tile_done)
  );

  store_addr_gen u_addr (
    .clk       (clk),
    .reset     (reset),
    .tile      (tile),
    .cmd_of    (cmd_of),
    .cmd_row   (cmd_row),
    .pos       (pos),
    .cmd_issue (cmd_issue),
    .rd_en     (rd_en),
    .cmd       (cmd),
    .beat_addr (beat_addr)
  );

  conv_out_fifo_bank u_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (fifo_wr_en),
    .wr       (fifo_wr),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  ddr_word_packer u_pack (
    .clk         (clk),
    .reset       (reset),
    .mode        (tile.mode),
    .rd_valid    (rd_valid),
    .pair_second (pair_second),
    .rd_data     (rd_data),
    .beat_addr   (beat_addr),
    .beat_valid  (beat_valid),
    .beat        (beat)
  );

endmodule

/* hw/ddr_word_packer.sv */
`timescale 1ns/10ps
`include "conv_store_cfg.svh"

module ddr_word_packer (
  input  logic                          clk,
  input  logic                          reset,
  input  conv_store_pkg::store_mode_e   mode,
  input  logic                          rd_valid,
  input  logic                          pair_second,
  input  logic [`CS_FIFO_WIDTH-1:0]     rd_data,
  input  logic [31:0]                   beat_addr,
  output logic                          beat_valid,
  output conv_store_pkg::ddr_beat_t     beat
);

  logic                     is_1x8;
  logic [`CS_CONV_WORD-1:0] first_word;
  logic                     have_first;
  logic                     take_first;

  assign is_1x8     = (mode == conv_store_pkg::MODE_1X8);
  assign take_first = rd_valid && !is_1x8 && !pair_second;

  ////////////////////////////////
  // 8x8 pair holding
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      have_first <= 1'b0;
    end else if (take_first) begin
      have_first <= 1'b1;
    end else if (rd_valid && pair_second) begin
      have_first <= 1'b0;
    end
  end

  // earlier conv word of the pair
  always_ff @(posedge clk) begin
    if (take_first) begin
      first_word <= rd_data[`CS_CONV_WORD-1:0];
    end
  end

  ////////////////////////////////
  // beat out
  ////////////////////////////////

  always_comb begin
    if (is_1x8) begin
      beat_valid = rd_valid;
      beat.data  = rd_data;
    end else begin
      beat_valid = rd_valid && pair_second && have_first;
      // later word goes in the upper half
      beat.data  = {rd_data[`CS_CONV_WORD-1:0], first_word};
    end
    beat.addr = beat_addr;
  end

endmodule

/* hw/store_addr_gen.sv */
`timescale 1ns/10ps
`include "conv_store_cfg.svh"

module store_addr_gen (
  input  logic                        clk,
  input  logic                        reset,
  input  conv_store_pkg::tile_desc_t  tile,
  input  logic [15:0]                 cmd_of,
  input  logic [15:0]                 cmd_row,
  input  conv_store_pkg::loop_pos_t   pos,
  input  logic                        cmd_issue,
  input  logic                        rd_en,
  output conv_store_pkg::ddr_cmd_t    cmd,
  output logic [31:0]                 beat_addr
);

  // ddr word address of a row and channel offset within the tile
  function automatic logic [31:0] word_addr(input conv_store_pkg::tile_desc_t t,
                                            input logic [15:0] row,
                                            input logic [15:0] ch_off);
    logic [31:0] row_idx;
    logic [31:0] x_words;
    logic [31:0] ch_words;
    logic [4:0]  row_shift;
    logic [4:0]  x_shift;
    row_idx   = {16'd0, t.oy_start} + {16'd0, row} - 32'd2;
    row_shift = {1'b0, t.of_log2} + {1'b0, t.ox_log2} - 5'(`CS_PIXELS_LOG2 + 1);
    x_shift   = {1'b0, t.of_log2} - 5'd1;
    x_words   = (({16'd0, t.ox_start} - 32'd1) << x_shift) >> `CS_PIXELS_LOG2;
    // two channels per word
    ch_words  = ({16'd0, t.of_start} - 32'd1 + {16'd0, ch_off}) >> 1;
    return t.layer_base + (row_idx << row_shift) + x_words + ch_words;
  endfunction

  // command fields only while issuing
  always_comb begin
    cmd = '0;
    if (cmd_issue) begin
      cmd.addr   = word_addr(tile, cmd_row, cmd_of);
      cmd.length = conv_store_pkg::cmd_length(tile.pof, cmd_of);
    end
  end

  // lands together with the fifo read data
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_addr <= '0;
    end else if (rd_en) begin
      beat_addr <= word_addr(tile, pos.oy, pos.of_base + pos.channel);
    end
  end

endmodule

/* hw/store_loop_counter.sv */
`timescale 1ns/10ps
`include "conv_store_cfg.svh"

module store_loop_counter (
  input  logic                          clk,
  input  logic                          reset,
  input  conv_store_pkg::store_state_e  state,
  input  conv_store_pkg::tile_desc_t    tile,
  input  logic                          cmd_issue,
  input  logic                          ddr_data_ready,
  output logic                          rd_en,
  output logic [3:0]                    rd_index,
  output conv_store_pkg::loop_pos_t     pos,
  output logic                          pair_second,
  output logic [15:0]                   cmd_of,
  output logic [15:0]                   cmd_row,
  output logic                          cmd_last,
  output logic                          burst_done,
  output logic                          tile_done
);

  logic        is_1x8;
  logic [15:0] chan_per_group;
  logic [15:0] chan_step;
  logic [3:0]  group_log2;
  logic [15:0] row;
  logic [15:0] of_base;
  logic [15:0] channel;
  logic        second_q;
  logic [15:0] beat_cnt;
  logic [15:0] burst_len;
  logic        beat_read;
  logic [15:0] chan_next;
  logic        chan_wrap;
  logic        row_wrap;
  logic        last_row;
  logic [15:0] cmd_len;
  logic        cmd_row_end;
  logic [15:0] index_wide;

  assign is_1x8         = (tile.mode == conv_store_pkg::MODE_1X8);
  assign chan_per_group = is_1x8 ? 16'(2 * `CS_ROWS_IN_SA) : 16'(`CS_ROWS_IN_SA);
  assign group_log2     = is_1x8 ? 4'(`CS_ROWS_IN_SA_LOG2 + 1) : 4'(`CS_ROWS_IN_SA_LOG2);
  assign chan_step      = is_1x8 ? 16'd2 : 16'd1;

  ////////////////////////////////
  // data side
  ////////////////////////////////

  // second read of an 8x8 pair goes out without ready
  assign rd_en     = (state == conv_store_pkg::ST_DATA) &&
                     (second_q || (ddr_data_ready && (beat_cnt != burst_len)));
  assign beat_read = rd_en && (is_1x8 || second_q);

  assign chan_next = of_base + channel + chan_step;
  assign row_wrap  = (chan_next >= tile.pof);
  assign chan_wrap = ((channel + chan_step) == chan_per_group) || row_wrap;
  assign last_row  = (row == tile.poy);

  assign index_wide = (row - 16'd1) * 16'(`CS_SA_ROWS) + (of_base >> group_log2);
  assign rd_index   = index_wide[3:0];

  assign pos.oy      = row;
  assign pos.of_base = of_base;
  assign pos.channel = channel;

  // describes the read whose data arrives this cycle
  assign pair_second = !is_1x8 && !second_q;

  always_ff @(posedge clk) begin
    if (reset || (state == conv_store_pkg::ST_IDLE)) begin
      row      <= 16'd1;
      of_base  <= '0;
      channel  <= '0;
      second_q <= 1'b0;
    end else if (rd_en) begin
      second_q <= !is_1x8 && !second_q;
      if (!chan_wrap) begin
        channel <= channel + chan_step;
      end else begin
        channel <= '0;
        if (row_wrap) begin
          of_base <= '0;
          row     <= last_row ? 16'd1 : row + 16'd1;
        end else begin
          of_base <= of_base + chan_per_group;
        end
      end
    end
  end

  // beats per command
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt   <= '0;
      burst_len  <= '0;
      burst_done <= 1'b0;
    end else begin
      burst_done <= beat_read && ((beat_cnt + 16'd1) == burst_len);
      if (cmd_issue) begin
        beat_cnt  <= '0;
        burst_len <= cmd_len;
      end else if (beat_read) begin
        beat_cnt <= beat_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || (state == conv_store_pkg::ST_DONE)) begin
      tile_done <= 1'b0;
    end else if (rd_en && row_wrap && last_row) begin
      tile_done <= 1'b1;
    end
  end

  ////////////////////////////////
  // command side
  ////////////////////////////////

  assign cmd_len     = conv_store_pkg::cmd_length(tile.pof, cmd_of);
  assign cmd_row_end = (cmd_of + (cmd_len << 1)) >= tile.pof;
  assign cmd_last    = cmd_row_end && (cmd_row == tile.poy);

  always_ff @(posedge clk) begin
    if (reset || (state == conv_store_pkg::ST_IDLE)) begin
      cmd_of  <= '0;
      cmd_row <= 16'd1;
    end else if (cmd_issue) begin
      if (cmd_row_end) begin
        cmd_of  <= '0;
        cmd_row <= cmd_last ? 16'd1 : cmd_row + 16'd1;
      end else begin
        cmd_of <= cmd_of + (cmd_len << 1);
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the conv store testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal \
  --top-module conv_store_tb \
  -f verilog.f \
  -o conv_store_sim
./obj_dir/conv_store_sim | tee sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

/* tests/conv_store_tb.sv */
`timescale 1ns/10ps
`include "conv_store_cfg.svh"

module conv_store_tb;

  localparam int NUM_TILES = 4;
  localparam int TIMEOUT   = 20000;

  logic                            clk;
  logic                            reset;
  logic                            fifo_wr_en;
  conv_store_pkg::fifo_wr_t        fifo_wr;
  conv_store_pkg::tile_desc_t      tile;
  logic                            store_start;
  logic                            ddr_cmd_ready;
  logic                            ddr_data_ready;
  logic                            cmd_valid;
  conv_store_pkg::ddr_cmd_t        cmd;
  logic                            beat_valid;
  conv_store_pkg::ddr_beat_t       beat;
  logic                            store_fin;

  conv_store_pkg::tile_desc_t      tiles [NUM_TILES];
  string                           tile_names [NUM_TILES];
  int                              wr_seq [`CS_FIFO_NUM];

  conv_store_pkg::ddr_cmd_t        exp_cmds [$];
  conv_store_pkg::ddr_beat_t       exp_beats [$];
  conv_store_pkg::ddr_cmd_t        got_cmds [$];
  conv_store_pkg::ddr_beat_t       got_beats [$];
  int                              burst_beats [$];

  int  mismatch_errs = 0;
  int  proto_errs = 0;
  int  timeout_errs = 0;
  int  fin_cnt = 0;
  int  cycle = 0;
  int  last_beat_cycle = -10;
  int  beats_in_burst = 0;
  bit  seen_cmd = 0;
  bit  busy = 0;
  bit  data_rdy_d1 = 0;
  bit  data_rdy_d2 = 0;

  conv_store_top u_dut (
    .clk            (clk),
    .reset          (reset),
    .fifo_wr_en     (fifo_wr_en),
    .fifo_wr        (fifo_wr),
    .tile           (tile),
    .store_start    (store_start),
    .ddr_cmd_ready  (ddr_cmd_ready),
    .ddr_data_ready (ddr_data_ready),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .beat_valid     (beat_valid),
    .beat           (beat),
    .store_fin      (store_fin)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  function automatic conv_store_pkg::tile_desc_t tile_entry(
      input conv_store_pkg::store_mode_e mode, input int pof, input int poy,
      input int ox_start, input int oy_start, input int of_start,
      input int of_log2, input int ox_log2, input logic [31:0] base);
    conv_store_pkg::tile_desc_t t;
    t.layer_base = base;
    t.mode       = mode;
    t.of_log2    = 4'(of_log2);
    t.ox_log2    = 4'(ox_log2);
    t.ox_start   = 16'(ox_start);
    t.oy_start   = 16'(oy_start);
    t.of_start   = 16'(of_start);
    t.poy        = 16'(poy);
    t.pof        = 16'(pof);
    return t;
  endfunction

  // word address of an output row and a channel offset counted from 0
  function automatic logic [31:0] ddr_word_addr(input conv_store_pkg::tile_desc_t t,
                                                input int row, input int ch);
    int unsigned row_words;
    int unsigned x_words;
    int unsigned ch_words;
    row_words = (int'(t.oy_start) + row - 2) << (int'(t.of_log2) + int'(t.ox_log2) - 6);
    x_words   = ((int'(t.ox_start) - 1) << (int'(t.of_log2) - 1)) >> 5;
    ch_words  = (int'(t.of_start) - 1 + ch) >> 1;
    return t.layer_base + row_words + x_words + ch_words;
  endfunction

  // each 32-bit lane tagged with fifo, sequence and lane number
  function automatic logic [`CS_FIFO_WIDTH-1:0] fifo_entry(input int fifo, input int seq);
    logic [`CS_FIFO_WIDTH-1:0] d;
    for (int lane = 0; lane < `CS_FIFO_WIDTH / 32; lane++) begin
      d[lane*32 +: 32] = {8'(fifo), 16'(seq), 8'(lane)};
    end
    return d;
  endfunction

  task automatic expected_cmds(input conv_store_pkg::tile_desc_t t);
    conv_store_pkg::ddr_cmd_t c;
    int off;
    int len;
    for (int row = 1; row <= int'(t.poy); row++) begin
      off = 0;
      while (off < int'(t.pof)) begin
        len = (int'(t.pof) - off >= 2 * `CS_CMD_WORDS) ? `CS_CMD_WORDS
                                                       : (int'(t.pof) - off) / 2;
        c.addr   = ddr_word_addr(t, row, off);
        c.length = 16'(len);
        exp_cmds.push_back(c);
        off += 2 * len;
      end
    end
  endtask

  // fills the fifos in read order and builds the expected beats
  task automatic preload_tile(input conv_store_pkg::tile_desc_t t);
    conv_store_pkg::ddr_beat_t b;
    logic [`CS_FIFO_WIDTH-1:0] word;
    logic [`CS_CONV_WORD-1:0]  held;
    int step;
    int group_size;
    int fifo;
    step       = (t.mode == conv_store_pkg::MODE_1X8) ? 2 : 1;
    group_size = (t.mode == conv_store_pkg::MODE_1X8) ? 2 * `CS_ROWS_IN_SA : `CS_ROWS_IN_SA;
    held       = '0;
    for (int row = 1; row <= int'(t.poy); row++) begin
      for (int ch = 0; ch < int'(t.pof); ch += step) begin
        fifo = (row - 1) * `CS_SA_ROWS + ch / group_size;
        word = fifo_entry(fifo, wr_seq[fifo]);
        wr_seq[fifo]++;
        @(negedge clk);
        fifo_wr_en    = 1'b1;
        fifo_wr.index = 4'(fifo);
        fifo_wr.data  = word;
        if (step == 2) begin
          b.addr = ddr_word_addr(t, row, ch);
          b.data = word;
          exp_beats.push_back(b);
        end else if (ch % 2 == 0) begin
          held = word[`CS_CONV_WORD-1:0];
        end else begin
          // later channel in the upper half
          b.addr = ddr_word_addr(t, row, ch - 1);
          b.data = {word[`CS_CONV_WORD-1:0], held};
          exp_beats.push_back(b);
        end
      end
    end
    @(negedge clk);
    fifo_wr_en = 1'b0;
  endtask

  task automatic compare_value(input string name, input logic [`CS_FIFO_WIDTH-1:0] expected,
                               input logic [`CS_FIFO_WIDTH-1:0] actual);
    if (expected !== actual) begin
      mismatch_errs++;
      $display("Mismatch %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  ////////////////////////////////
  // ddr model
  ////////////////////////////////

  initial begin
    void'($urandom(32'hd980_4f33));
    ddr_cmd_ready  = 1'b0;
    ddr_data_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        ddr_cmd_ready  = ($urandom % 4) != 0;
        ddr_data_ready = ($urandom % 3) != 0;
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (!reset) begin
      if (!busy && (cmd_valid || beat_valid || store_fin)) begin
        proto_errs++;
        $display("output active with no store running at cycle %0d", cycle);
      end
      if (cmd_valid) begin
        if (!ddr_cmd_ready) begin
          proto_errs++;
          $display("command issued while ddr_cmd_ready was low at cycle %0d", cycle);
        end
        if (seen_cmd) begin
          burst_beats.push_back(beats_in_burst);
        end
        seen_cmd       = 1'b1;
        beats_in_burst = 0;
        got_cmds.push_back(cmd);
      end
      if (beat_valid) begin
        // the 1x8 read is one cycle back and the 8x8 pair start two cycles back
        if ((tile.mode == conv_store_pkg::MODE_1X8) ? !data_rdy_d1 : !data_rdy_d2) begin
          proto_errs++;
          $display("beat read started while ddr_data_ready was low at cycle %0d", cycle);
        end
        got_beats.push_back(beat);
        beats_in_burst++;
        last_beat_cycle = cycle;
      end
      if (store_fin) begin
        fin_cnt++;
        if (cycle != last_beat_cycle + 1) begin
          proto_errs++;
          $display("store_fin not one cycle after the last beat at cycle %0d", cycle);
        end
        if (seen_cmd) begin
          burst_beats.push_back(beats_in_burst);
        end
        seen_cmd = 1'b0;
      end
    end
    data_rdy_d2 = data_rdy_d1;
    data_rdy_d1 = ddr_data_ready;
  end

  ////////////////////////////////
  // tile sequence
  ////////////////////////////////

  initial begin
    int cmd_base;
    int beat_base;
    int burst_base;
    int fin_base;
    int wait_cycles;
    bit timed_out;
    string name;

    reset       = 1'b1;
    fifo_wr_en  = 1'b0;
    fifo_wr     = '0;
    tile        = '0;
    store_start = 1'b0;
    timed_out   = 1'b0;
    for (int i = 0; i < `CS_FIFO_NUM; i++) begin
      wr_seq[i] = 0;
    end

    tile_names[0] = "conv8_full";
    tiles[0] = tile_entry(conv_store_pkg::MODE_8X8, 64, 3, 1, 1, 1, 6, 5, 32'h0000_1000);
    tile_names[1] = "conv1_short_cmd";
    tiles[1] = tile_entry(conv_store_pkg::MODE_1X8, 80, 2, 5, 3, 1, 7, 4, 32'h0002_0000);
    tile_names[2] = "conv8_partial";
    tiles[2] = tile_entry(conv_store_pkg::MODE_8X8, 24, 2, 33, 2, 17, 5, 3, 32'h0004_0000);
    tile_names[3] = "conv1_two_cmds";
    tiles[3] = tile_entry(conv_store_pkg::MODE_1X8, 128, 3, 2, 1, 33, 8, 2, 32'h8000_0000);

    repeat (5) @(negedge clk);
    reset = 1'b0;
    // outputs must stay quiet while idle with random ready levels
    repeat (10) @(negedge clk);

    for (int t = 0; t < NUM_TILES && !timed_out; t++) begin
      exp_cmds.delete();
      exp_beats.delete();
      tile = tiles[t];
      expected_cmds(tiles[t]);
      preload_tile(tiles[t]);

      cmd_base   = got_cmds.size();
      beat_base  = got_beats.size();
      burst_base = burst_beats.size();
      fin_base   = fin_cnt;
      @(negedge clk);
      store_start = 1'b1;
      busy        = 1'b1;
      @(negedge clk);
      store_start = 1'b0;

      wait_cycles = 0;
      while (fin_cnt == fin_base && wait_cycles < TIMEOUT) begin
        @(negedge clk);
        wait_cycles++;
      end
      busy = 1'b0;
      if (fin_cnt == fin_base) begin
        timeout_errs++;
        timed_out = 1'b1;
        $display("timeout waiting for store_fin on %s", tile_names[t]);
      end else begin
        // a second store_fin would show up here
        repeat (3) @(negedge clk);
        name = tile_names[t];
        compare_value({name, " store_fin count"}, 1, fin_cnt - fin_base);
        compare_value({name, " cmd count"}, exp_cmds.size(), got_cmds.size() - cmd_base);
        compare_value({name, " beat count"}, exp_beats.size(), got_beats.size() - beat_base);
        for (int k = 0; k < exp_cmds.size(); k++) begin
          if (cmd_base + k < got_cmds.size()) begin
            compare_value($sformatf("%s cmd %0d addr", name, k),
                          exp_cmds[k].addr, got_cmds[cmd_base + k].addr);
            compare_value($sformatf("%s cmd %0d length", name, k),
                          exp_cmds[k].length, got_cmds[cmd_base + k].length);
          end
          if (burst_base + k < burst_beats.size()) begin
            compare_value($sformatf("%s cmd %0d beats", name, k),
                          exp_cmds[k].length, burst_beats[burst_base + k]);
          end
        end
        for (int k = 0; k < exp_beats.size(); k++) begin
          if (beat_base + k < got_beats.size()) begin
            compare_value($sformatf("%s beat %0d addr", name, k),
                          exp_beats[k].addr, got_beats[beat_base + k].addr);
            compare_value($sformatf("%s beat %0d data", name, k),
                          exp_beats[k].data, got_beats[beat_base + k].data);
          end
        end
      end
    end

    $display("errors: mismatch %0d, protocol %0d, timeout %0d",
             mismatch_errs, proto_errs, timeout_errs);
    if (mismatch_errs + proto_errs + timeout_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hw
hw/conv_store_pkg.sv
hw/conv_out_fifo_bank.sv
hw/store_loop_counter.sv
hw/store_addr_gen.sv
hw/ddr_word_packer.sv
hw/conv_store_fsm.sv
hw/conv_store_top.sv
tests/conv_store_tb.sv
